// ==== rtl/spmm_settings.svh ====
`ifndef SPMM_SETTINGS_SVH
`define SPMM_SETTINGS_SVH

// element widths
`define SPMM_DATA_WIDTH        8
// accumulator width
// sums wrap modulo 2^12
`define SPMM_WH_DATA_WIDTH     12

// matrix shape
// columns of H and rows of W
`define SPMM_NUM_FEATURE_IN    64
// one lane per output feature
`define SPMM_NUM_FEATURE_OUT   4

// compressed row fields
`define SPMM_COL_IDX_WIDTH     6
// row length 1 to 64
`define SPMM_ROW_LEN_WIDTH     7
`define SPMM_NUM_NODE_WIDTH    8

// memory address widths
// node-info and wh memories share one width
`define SPMM_H_DATA_ADDR_W     10
`define SPMM_NODE_INFO_ADDR_W  8

// node-info prefetch depth
`define SPMM_NODE_FIFO_DEPTH   4

`endif

// ==== rtl/spmm_pkg.sv ====
`include "spmm_settings.svh"

package spmm_pkg;

  // one data-memory entry of H
  typedef struct packed {
    logic [`SPMM_COL_IDX_WIDTH-1:0]   col_idx;
    logic [`SPMM_DATA_WIDTH-1:0]      val;
  } h_data_t;

  // one node-info word per row of H
  typedef struct packed {
    logic [`SPMM_ROW_LEN_WIDTH-1:0]   row_len;
    logic [`SPMM_NUM_NODE_WIDTH-1:0]  num_node;
    logic                             src_flag;
  } node_info_t;

  // one row of W
  // element j feeds lane j
  typedef logic [`SPMM_NUM_FEATURE_OUT-1:0][`SPMM_DATA_WIDTH-1:0] wgt_row_t;

  // beat from controller to lanes
  // lined up with the W row
  typedef struct packed {
    logic                             valid;
    logic                             first;
    logic                             last;
    logic [`SPMM_DATA_WIDTH-1:0]      val;
  } pe_beat_t;

  // one Wh memory word
  // lane 0 sits in the top field
  typedef struct packed {
    logic [0:`SPMM_NUM_FEATURE_OUT-1][`SPMM_WH_DATA_WIDTH-1:0] res;
    logic [`SPMM_NUM_NODE_WIDTH-1:0]  num_node;
    logic                             src_flag;
  } wh_word_t;

endpackage

// ==== rtl/node_info_fifo.sv ====
`timescale 1ns/10ps
`include "spmm_settings.svh"

module node_info_fifo #(
  parameter int DATA_WIDTH = 16,
  parameter int DEPTH      = `SPMM_NODE_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_vld_i,
  input  logic [DATA_WIDTH-1:0] din_i,
  input  logic                  rd_vld_i,
  output logic [DATA_WIDTH-1:0] dout_o,
  output logic                  empty_o,
  output logic                  full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      cnt_q;
  logic                  do_wr;
  logic                  do_rd;

  // wrap at DEPTH-1 so depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // push into a full fifo or pop from an empty one is dropped
  assign do_wr   = wr_vld_i && !full_o;
  assign do_rd   = rd_vld_i && !empty_o;
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));

  // head entry always visible as in first-word fall-through
  assign dout_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_rd) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // count follows the net change
      if (do_wr && !do_rd) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_rd && !do_wr) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/spmm_ctrl.sv ====
`timescale 1ns/10ps
`include "spmm_settings.svh"

module spmm_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              spmm_vld_i,
  input  logic [`SPMM_NODE_INFO_ADDR_W-1:0] row_count_i,
  output logic [`SPMM_NODE_INFO_ADDR_W-1:0] node_info_addr_o,
  input  spmm_pkg::node_info_t              node_info_dout_i,
  output logic                              fifo_push_o,
  output spmm_pkg::node_info_t              fifo_din_o,
  output logic                              fifo_pop_o,
  input  spmm_pkg::node_info_t              fifo_dout_i,
  input  logic                              fifo_empty_i,
  input  logic                              fifo_full_i,
  output logic [`SPMM_H_DATA_ADDR_W-1:0]    h_data_addr_o,
  input  spmm_pkg::h_data_t                 h_data_dout_i,
  output logic [`SPMM_COL_IDX_WIDTH-1:0]    wgt_addr_o,
  output spmm_pkg::pe_beat_t                beat_o,
  output spmm_pkg::node_info_t              row_info_o,
  output logic                              done_o
);
  import spmm_pkg::*;

  localparam int DEPTH = `SPMM_NODE_FIFO_DEPTH;
  localparam int OCC_W = $clog2(DEPTH + 1);
  // issue of final entry to cycle after its wh write
  localparam int DRAIN = 4;

  logic                              fetching_q;
  logic                              fetch_en;
  logic                              push_q;
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] ni_addr_q;
  logic [OCC_W-1:0]                  occ_q;
  node_info_t                        cur_row_q;
  logic                              row_active_q;
  logic [`SPMM_ROW_LEN_WIDTH-1:0]    ent_cnt_q;
  logic [`SPMM_H_DATA_ADDR_W-1:0]    data_addr_q;
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] pop_cnt_q;
  logic                              issue_first;
  logic                              issue_last;
  logic                              issue_final;
  logic                              pop;
  logic                              s1_vld_q;
  logic                              s1_first_q;
  logic                              s1_last_q;
  logic                              b_vld_q;
  logic                              b_first_q;
  logic                              b_last_q;
  logic [`SPMM_DATA_WIDTH-1:0]       b_val_q;
  node_info_t                        s1_info_q;
  node_info_t                        s2_info_q;
  node_info_t                        s3_info_q;
  logic [DRAIN-1:0]                  fin_q;
  logic                              done_q;

  // ============================
  // node-info prefetch
  // ============================
  // occ_q counts fifo entries plus the push in flight
  assign fetch_en         = fetching_q && !fifo_full_i && (occ_q < OCC_W'(DEPTH));
  assign node_info_addr_o = ni_addr_q;
  // memory data returns one cycle after the read
  assign fifo_push_o      = push_q;
  assign fifo_din_o       = node_info_dout_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetching_q <= 1'b0;
      push_q     <= 1'b0;
      ni_addr_q  <= '0;
      occ_q      <= '0;
    end else begin
      push_q <= fetch_en;
      if (fetch_en && !pop) begin
        occ_q <= occ_q + 1'b1;
      end else if (pop && !fetch_en) begin
        occ_q <= occ_q - 1'b1;
      end
      if (spmm_vld_i) begin
        fetching_q <= 1'b1;
        ni_addr_q  <= '0;
      end else if (fetch_en) begin
        ni_addr_q <= ni_addr_q + 1'b1;
        // stop after row row_count_i-1
        if (ni_addr_q == row_count_i - 1'b1) begin
          fetching_q <= 1'b0;
        end
      end
    end
  end

  // ============================
  // entry stepper
  // ============================
  assign issue_first   = row_active_q && (ent_cnt_q == '0);
  assign issue_last    = row_active_q && (ent_cnt_q == cur_row_q.row_len - 1'b1);
  assign issue_final   = issue_last && (pop_cnt_q == row_count_i);
  // next row loads on the last entry with no bubble
  assign pop           = !fifo_empty_i && (!row_active_q || issue_last);
  assign fifo_pop_o    = pop;
  assign h_data_addr_o = data_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_active_q <= 1'b0;
      ent_cnt_q    <= '0;
      data_addr_q  <= '0;
      pop_cnt_q    <= '0;
    end else if (spmm_vld_i) begin
      row_active_q <= 1'b0;
      ent_cnt_q    <= '0;
      data_addr_q  <= '0;
      pop_cnt_q    <= '0;
    end else begin
      // data address runs on across row boundaries
      if (row_active_q) begin
        data_addr_q <= data_addr_q + 1'b1;
        ent_cnt_q   <= issue_last ? '0 : ent_cnt_q + 1'b1;
      end
      if (pop) begin
        row_active_q <= 1'b1;
        pop_cnt_q    <= pop_cnt_q + 1'b1;
      end else if (issue_last) begin
        row_active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      cur_row_q <= fifo_dout_i;
    end
  end

  // ============================
  // entry pipeline
  // ============================
  // col_idx addresses W as soon as the entry returns
  assign wgt_addr_o = h_data_dout_i.col_idx;
  assign beat_o     = '{valid: b_vld_q, first: b_first_q, last: b_last_q, val: b_val_q};
  // lines up with the lane results one cycle past the beat
  assign row_info_o = s3_info_q;
  assign done_o     = done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q   <= 1'b0;
      s1_first_q <= 1'b0;
      s1_last_q  <= 1'b0;
      b_vld_q    <= 1'b0;
      b_first_q  <= 1'b0;
      b_last_q   <= 1'b0;
      fin_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      s1_vld_q   <= row_active_q;
      s1_first_q <= issue_first;
      s1_last_q  <= issue_last;
      b_vld_q    <= s1_vld_q;
      b_first_q  <= s1_first_q;
      b_last_q   <= s1_last_q;
      fin_q      <= {fin_q[DRAIN-2:0], issue_final};
      // held until the next start pulse
      if (spmm_vld_i) begin
        done_q <= 1'b0;
      end else if (fin_q[DRAIN-1]) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    b_val_q   <= h_data_dout_i.val;
    s1_info_q <= cur_row_q;
    s2_info_q <= s1_info_q;
    s3_info_q <= s2_info_q;
  end

endmodule

// ==== rtl/sparse_pe.sv ====
`timescale 1ns/10ps
`include "spmm_settings.svh"

module sparse_pe (
  input  logic                           clk,
  input  logic                           rst_n,
  input  spmm_pkg::pe_beat_t             beat_i,
  input  logic [`SPMM_DATA_WIDTH-1:0]    wgt_i,
  output logic [`SPMM_WH_DATA_WIDTH-1:0] res_o,
  output logic                           res_valid_o
);

  localparam int PAD = `SPMM_WH_DATA_WIDTH - `SPMM_DATA_WIDTH;

  logic [`SPMM_WH_DATA_WIDTH-1:0] val_ext;
  logic [`SPMM_WH_DATA_WIDTH-1:0] wgt_ext;
  logic [`SPMM_WH_DATA_WIDTH-1:0] prod;
  logic [`SPMM_WH_DATA_WIDTH-1:0] acc_q;

  // operands widened to the result width
  assign val_ext = {{PAD{1'b0}}, beat_i.val};
  assign wgt_ext = {{PAD{1'b0}}, wgt_i};
  // product and sum both wrap modulo 2^12
  assign prod    = val_ext * wgt_ext;

  // first entry of a row restarts the sum
  always_ff @(posedge clk) begin
    if (beat_i.valid) begin
      if (beat_i.first) begin
        acc_q <= prod;
      end else begin
        acc_q <= acc_q + prod;
      end
    end
  end

  // one-cycle flag after the last entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= beat_i.valid && beat_i.last;
    end
  end

  // sum is final while res_valid_o is high
  // next row's first beat overwrites it a cycle later
  assign res_o = acc_q;

endmodule

// ==== rtl/wh_writer.sv ====
`timescale 1ns/10ps
`include "spmm_settings.svh"

module wh_writer (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      start_i,
  input  logic                                                      res_valid_i,
  input  logic [0:`SPMM_NUM_FEATURE_OUT-1][`SPMM_WH_DATA_WIDTH-1:0] res_i,
  input  spmm_pkg::node_info_t                                      row_info_i,
  output spmm_pkg::wh_word_t                                        wh_bram_din_o,
  output logic                                                      wh_bram_ena_o,
  output logic [`SPMM_NODE_INFO_ADDR_W-1:0]                         wh_bram_addra_o,
  output spmm_pkg::wh_word_t                                        wh_data_o
);
  import spmm_pkg::*;

  wh_word_t                          word_d;
  wh_word_t                          word_q;
  logic                              ena_q;
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] addr_q;

  // lane results followed by the row's node fields
  assign word_d = '{
    res:      res_i,
    num_node: row_info_i.num_node,
    src_flag: row_info_i.src_flag
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ena_q  <= 1'b0;
      addr_q <= '0;
      word_q <= '0;
    end else begin
      ena_q <= res_valid_i;
      // word stays put between rows
      if (res_valid_i) begin
        word_q <= word_d;
      end
      // address moves on after each write
      if (start_i) begin
        addr_q <= '0;
      end else if (ena_q) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign wh_bram_ena_o   = ena_q;
  assign wh_bram_addra_o = addr_q;
  assign wh_bram_din_o   = word_q;
  // last written word held for the next stage
  assign wh_data_o       = word_q;

endmodule

// ==== rtl/spmm.sv ====
`timescale 1ns/10ps
`include "spmm_settings.svh"

module spmm (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              spmm_vld_i,
  input  logic [`SPMM_NODE_INFO_ADDR_W-1:0] row_count_i,
  output logic                              spmm_rdy_o,
  output logic                              done_o,
  output logic [`SPMM_H_DATA_ADDR_W-1:0]    h_data_bram_addrb_o,
  input  spmm_pkg::h_data_t                 h_data_bram_dout_i,
  output logic [`SPMM_NODE_INFO_ADDR_W-1:0] h_node_info_bram_addrb_o,
  input  spmm_pkg::node_info_t              h_node_info_bram_dout_i,
  output logic [`SPMM_COL_IDX_WIDTH-1:0]    mult_wgt_addrb_o,
  input  spmm_pkg::wgt_row_t                mult_wgt_dout_i,
  output spmm_pkg::wh_word_t                wh_bram_din_o,
  output logic                              wh_bram_ena_o,
  output logic [`SPMM_NODE_INFO_ADDR_W-1:0] wh_bram_addra_o,
  output spmm_pkg::wh_word_t                wh_data_o
);
  import spmm_pkg::*;

  node_info_t                                                fifo_din;
  node_info_t                                                fifo_dout;
  node_info_t                                                row_info;
  logic                                                      fifo_push;
  logic                                                      fifo_pop;
  logic                                                      fifo_empty;
  logic                                                      fifo_full;
  pe_beat_t                                                  beat;
  logic [0:`SPMM_NUM_FEATURE_OUT-1][`SPMM_WH_DATA_WIDTH-1:0] lane_res;
  logic [`SPMM_NUM_FEATURE_OUT-1:0]                          lane_vld;

  // ready pulses with each wh write
  assign spmm_rdy_o = wh_bram_ena_o;

  // ============================
  // control and prefetch
  // ============================
  spmm_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .spmm_vld_i       (spmm_vld_i),
    .row_count_i      (row_count_i),
    .node_info_addr_o (h_node_info_bram_addrb_o),
    .node_info_dout_i (h_node_info_bram_dout_i),
    .fifo_push_o      (fifo_push),
    .fifo_din_o       (fifo_din),
    .fifo_pop_o       (fifo_pop),
    .fifo_dout_i      (fifo_dout),
    .fifo_empty_i     (fifo_empty),
    .fifo_full_i      (fifo_full),
    .h_data_addr_o    (h_data_bram_addrb_o),
    .h_data_dout_i    (h_data_bram_dout_i),
    .wgt_addr_o       (mult_wgt_addrb_o),
    .beat_o           (beat),
    .row_info_o       (row_info),
    .done_o           (done_o)
  );

  node_info_fifo #(
    .DATA_WIDTH ($bits(node_info_t)),
    .DEPTH      (`SPMM_NODE_FIFO_DEPTH)
  ) u_node_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_vld_i (fifo_push),
    .din_i    (fifo_din),
    .rd_vld_i (fifo_pop),
    .dout_o   (fifo_dout),
    .empty_o  (fifo_empty),
    .full_o   (fifo_full)
  );

  // ============================
  // lanes and wh write
  // ============================
  // all lanes share the beat and one W row
  for (genvar g = 0; g < `SPMM_NUM_FEATURE_OUT; g++) begin : g_lane
    sparse_pe u_pe (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat_i      (beat),
      .wgt_i       (mult_wgt_dout_i[g]),
      .res_o       (lane_res[g]),
      .res_valid_o (lane_vld[g])
    );
  end

  // lanes run in lockstep so lane 0 flags for all
  wh_writer u_writer (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (spmm_vld_i),
    .res_valid_i     (lane_vld[0]),
    .res_i           (lane_res),
    .row_info_i      (row_info),
    .wh_bram_din_o   (wh_bram_din_o),
    .wh_bram_ena_o   (wh_bram_ena_o),
    .wh_bram_addra_o (wh_bram_addra_o),
    .wh_data_o       (wh_data_o)
  );

endmodule

// ==== tests/spmm_tb.sv ====
`timescale 1ns/10ps
`include "spmm_settings.svh"

module spmm_tb;
  import spmm_pkg::*;

  localparam int NUM_OUT  = `SPMM_NUM_FEATURE_OUT;
  localparam int NUM_IN   = `SPMM_NUM_FEATURE_IN;
  localparam int NI_DEPTH = 1 << `SPMM_NODE_INFO_ADDR_W;
  localparam int HD_DEPTH = 1 << `SPMM_H_DATA_ADDR_W;
  // single row, ten random rows, two full rows, restart run twice
  localparam int TOTAL_ENTRIES = 1 + 10 * 12 + 2 * 64 + 2 * 4 * 8;
  localparam int NUM_TESTS     = 6;
  localparam int RUN_MARGIN    = 60;
  localparam int CYCLE_LIMIT   = TOTAL_ENTRIES + NUM_TESTS * RUN_MARGIN;

  logic                              clk = 1'b0;
  logic                              rst_n;
  logic                              spmm_vld_i;
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] row_count_i;
  logic                              spmm_rdy_o;
  logic                              done_o;
  logic [`SPMM_H_DATA_ADDR_W-1:0]    h_data_addr;
  h_data_t                           h_data_q;
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] node_addr;
  node_info_t                        node_q;
  logic [`SPMM_COL_IDX_WIDTH-1:0]    wgt_addr;
  wgt_row_t                          wgt_q;
  wh_word_t                          wh_din;
  logic                              wh_ena;
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] wh_addr;
  wh_word_t                          wh_data;

  // memory models
  node_info_t node_mem [NI_DEPTH];
  h_data_t    data_mem [HD_DEPTH];
  wgt_row_t   wgt_mem  [NUM_IN];

  // captured writes and model results
  wh_word_t                          exp_word [NI_DEPTH];
  wh_word_t                          wr_word  [NI_DEPTH];
  wh_word_t                          wr_held  [NI_DEPTH];
  logic [`SPMM_NODE_INFO_ADDR_W-1:0] wr_addr  [NI_DEPTH];
  int                                wr_cnt;
  int                                rdy_cnt;
  int                                rdy_wr_cnt;
  int                                err_cnt;
  int                                chk_cnt;
  int                                cycle_cnt = 0;
  logic [31:0]                       rand_state;

  spmm spmm_inst (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .spmm_vld_i               (spmm_vld_i),
    .row_count_i              (row_count_i),
    .spmm_rdy_o               (spmm_rdy_o),
    .done_o                   (done_o),
    .h_data_bram_addrb_o      (h_data_addr),
    .h_data_bram_dout_i       (h_data_q),
    .h_node_info_bram_addrb_o (node_addr),
    .h_node_info_bram_dout_i  (node_q),
    .mult_wgt_addrb_o         (wgt_addr),
    .mult_wgt_dout_i          (wgt_q),
    .wh_bram_din_o            (wh_din),
    .wh_bram_ena_o            (wh_ena),
    .wh_bram_addra_o          (wh_addr),
    .wh_data_o                (wh_data)
  );

  always #10 clk = ~clk;

  // one-cycle read latency on all three memories
  always @(posedge clk) begin
    node_q   <= node_mem[node_addr];
    h_data_q <= data_mem[h_data_addr];
    wgt_q    <= wgt_mem[wgt_addr];
  end

  // ==============================
  // checks and helpers
  // ==============================
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // lcg with numerical recipes constants
  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // writes sampled at the negative edge where outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (spmm_rdy_o) begin
        rdy_cnt++;
      end
      // rdy counted again only where it coincides with a write
      if (spmm_rdy_o && wh_ena) begin
        rdy_wr_cnt++;
      end
      if (wh_ena && wr_cnt < NI_DEPTH) begin
        wr_addr[wr_cnt] = wh_addr;
        wr_word[wr_cnt] = wh_din;
        wr_held[wr_cnt] = wh_data;
        wr_cnt++;
      end
    end
  end

  // global watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // reference model
  // rows stored back to back from data address 0
  task automatic build_expected(input int nrows, output int entries);
    int         ptr;
    int         sum [NUM_OUT];
    node_info_t info;
    h_data_t    ent;
    wh_word_t   w;
    ptr = 0;
    for (int r = 0; r < nrows; r++) begin
      info = node_mem[r];
      for (int j = 0; j < NUM_OUT; j++) begin
        sum[j] = 0;
      end
      for (int e = 0; e < info.row_len; e++) begin
        ent = data_mem[ptr];
        ptr++;
        for (int j = 0; j < NUM_OUT; j++) begin
          sum[j] += ent.val * wgt_mem[ent.col_idx][j];
        end
      end
      // lane 0 lands in the top result field
      for (int j = 0; j < NUM_OUT; j++) begin
        w.res[j] = 12'(sum[j] % 4096);
      end
      w.num_node  = info.num_node;
      w.src_flag  = info.src_flag;
      exp_word[r] = w;
    end
    entries = ptr;
  endtask

  task automatic fill_weights_random();
    for (int c = 0; c < NUM_IN; c++) begin
      wgt_mem[c] = wgt_row_t'(next_random());
    end
  endtask

  task automatic build_random_rows(input int nrows, input int max_len);
    int          ptr;
    int          len;
    logic [31:0] r;
    ptr = 0;
    for (int row = 0; row < nrows; row++) begin
      r   = next_random();
      len = 1 + r[23:16] % max_len;
      node_mem[row] = '{row_len: 7'(len), num_node: r[7:0], src_flag: r[31]};
      for (int e = 0; e < len; e++) begin
        r = next_random();
        data_mem[ptr] = '{col_idx: r[29:24], val: r[15:8]};
        ptr++;
      end
    end
  endtask

  // start pulse then wait for done and compare every write with the model
  task automatic run_and_check(input string name, input int nrows);
    int entries;
    int waited;
    build_expected(nrows, entries);
    wr_cnt     = 0;
    rdy_cnt    = 0;
    rdy_wr_cnt = 0;
    @(posedge clk);
    spmm_vld_i  <= 1'b1;
    row_count_i <= nrows[`SPMM_NODE_INFO_ADDR_W-1:0];
    @(posedge clk);
    spmm_vld_i <= 1'b0;
    @(negedge clk);
    check_value({name, " data addr after start"}, 0, h_data_addr);
    check_value({name, " node addr after start"}, 0, node_addr);
    check_value({name, " wh addr after start"}, 0, wh_addr);
    check_value({name, " done cleared"}, 0, done_o);
    waited = 0;
    while (!done_o && waited < entries + RUN_MARGIN) begin
      @(negedge clk);
      waited++;
    end
    if (!done_o) begin
      err_cnt++;
      $display("%s: done_o did not rise within %0d cycles", name, entries + RUN_MARGIN);
    end
    check_value({name, " writes before done"}, nrows, wr_cnt);
    // rdy pulses on every write and nowhere else
    check_value({name, " rdy pulses"}, nrows, rdy_cnt);
    check_value({name, " rdy with write"}, nrows, rdy_wr_cnt);
    for (int i = 0; i < wr_cnt && i < nrows; i++) begin
      check_value($sformatf("%s row %0d addr", name, i), i, wr_addr[i]);
      check_value($sformatf("%s row %0d word", name, i), exp_word[i], wr_word[i]);
      check_value($sformatf("%s row %0d num_node", name, i),
                  exp_word[i].num_node, wr_word[i].num_node);
      check_value($sformatf("%s row %0d src_flag", name, i),
                  exp_word[i].src_flag, wr_word[i].src_flag);
      check_value($sformatf("%s row %0d wh_data", name, i), exp_word[i], wr_held[i]);
    end
    // last word stays on wh_data_o
    check_value({name, " wh_data held"}, exp_word[nrows-1], wh_data);
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic reset_idle();
    check_value("reset ena", 0, wh_ena);
    check_value("reset rdy", 0, spmm_rdy_o);
    check_value("reset done", 0, done_o);
    check_value("reset wh addr", 0, wh_addr);
    check_value("reset wh_data", 0, wh_data);
    check_value("reset data addr", 0, h_data_addr);
    repeat (8) @(negedge clk);
    check_value("idle writes", 0, wr_cnt);
    check_value("idle rdy", 0, rdy_cnt);
  endtask

  task automatic single_row();
    node_mem[0] = '{row_len: 7'd1, num_node: 8'd17, src_flag: 1'b1};
    data_mem[0] = '{col_idx: 6'd5, val: 8'd3};
    fill_weights_random();
    run_and_check("single_row", 1);
    repeat (3) @(negedge clk);
    check_value("single_row done held", 1, done_o);
  endtask

  task automatic random_rows();
    fill_weights_random();
    build_random_rows(10, 12);
    run_and_check("random_rows", 10);
  endtask

  // 64 * 255 * 255 overflows the 12-bit sum
  task automatic wrap_rows();
    for (int c = 0; c < NUM_IN; c++) begin
      for (int j = 0; j < NUM_OUT; j++) begin
        wgt_mem[c][j] = 8'hff;
      end
    end
    for (int row = 0; row < 2; row++) begin
      node_mem[row] = '{row_len: 7'd64, num_node: 8'(row + 200), src_flag: row[0]};
      for (int e = 0; e < 64; e++) begin
        data_mem[row * 64 + e] = '{col_idx: 6'(e), val: 8'hff};
      end
    end
    run_and_check("wrap", 2);
  endtask

  task automatic restart_run();
    fill_weights_random();
    build_random_rows(4, 8);
    run_and_check("restart_first", 4);
    check_value("restart wh addr before start", 4, wh_addr);
    run_and_check("restart_second", 4);
  endtask

  initial begin
    rand_state  = 32'h175a_52b2;
    err_cnt     = 0;
    chk_cnt     = 0;
    wr_cnt      = 0;
    rdy_cnt     = 0;
    rdy_wr_cnt  = 0;
    rst_n       = 1'b0;
    spmm_vld_i  = 1'b0;
    row_count_i = '0;
    node_q      = '0;
    h_data_q    = '0;
    wgt_q       = '0;
    for (int a = 0; a < NI_DEPTH; a++) begin
      node_mem[a] = '0;
    end
    for (int a = 0; a < HD_DEPTH; a++) begin
      data_mem[a] = '0;
    end
    for (int a = 0; a < NUM_IN; a++) begin
      wgt_mem[a] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_idle();
    single_row();
    random_rows();
    wrap_rows();
    restart_run();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== spmm.f ====
+incdir+rtl
rtl/spmm_pkg.sv
rtl/node_info_fifo.sv
rtl/spmm_ctrl.sv
rtl/sparse_pe.sv
rtl/wh_writer.sv
rtl/spmm.sv
tests/spmm_tb.sv
